// File: vector_subtract.f
src/vecsub_pkg.sv
src/operand_loader.sv
src/tile_subtractor.sv
src/result_collector.sv
src/vector_subtract.sv
tb/vector_subtract_chk.sv
tb/tb_vector_subtract.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the vector_subtract testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_vector_subtract \
    --Mdir obj_dir \
    -f vector_subtract.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_output=$(./obj_dir/Vtb_vector_subtract 2>&1)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_output" | grep -qx "TEST PASSED"; then
    exit 0
fi
exit 1

// File: tb/tb_vector_subtract.sv
`timescale 1ns/10ps
`default_nettype none

module tb_vector_subtract
    import vecsub_pkg::*;
();

    localparam int STREAM_LEN     = 20;
    // Reference 1, overflow 3, two streams, reset test 3 plus 1
    localparam int VECTORS_SENT   = 1 + 3 + 2 * STREAM_LEN + 4;
    localparam int TIMEOUT_CYCLES = 8 * VECTORS_SENT + 200;

    logic                    clk;
    logic                    rst;
    logic                    in_valid;
    logic [VECTOR_WIDTH-1:0] in_a;
    logic [VECTOR_WIDTH-1:0] in_b;
    logic                    in_ready;
    logic                    out_valid;
    logic [VECTOR_WIDTH-1:0] out_result;
    logic                    out_error;
    logic                    out_ready;

    // Scoreboard entries hold {error, result}
    logic [VECTOR_WIDTH:0]   exp_q[$];
    logic [VECTOR_WIDTH:0]   head;

    logic [31:0]             lfsr_state = 32'he640_f627;
    int                      cycle_cnt;
    int                      gap_cnt;
    int                      outputs_seen;
    logic                    gap_check;
    logic                    gap_armed;
    logic                    saw_in_stall;
    logic                    sending_done;
    logic [VECTOR_WIDTH-1:0] stress_a [STREAM_LEN];
    logic [VECTOR_WIDTH-1:0] stress_b [STREAM_LEN];

    vector_subtract vector_subtract_i (.*);

    always #50 clk = ~clk;

    //////////////////////////////////////////////////////////////////////
    // Reference model and random source
    //////////////////////////////////////////////////////////////////////

    function automatic logic [VECTOR_WIDTH:0] model_diff(input logic [VECTOR_WIDTH-1:0] a,
                                                         input logic [VECTOR_WIDTH-1:0] b);
        logic signed [CELL_WIDTH:0] d;
        logic [VECTOR_WIDTH-1:0]    r;
        logic                       e;
        r = '0;
        e = 1'b0;
        for (int i = 0; i < VECTOR_LEN; i++) begin
            // True 9-bit difference of sign-extended cells
            d = $signed({a[i*CELL_WIDTH+CELL_WIDTH-1], a[i*CELL_WIDTH +: CELL_WIDTH]}) -
                $signed({b[i*CELL_WIDTH+CELL_WIDTH-1], b[i*CELL_WIDTH +: CELL_WIDTH]});
            r[i*CELL_WIDTH +: CELL_WIDTH] = d[CELL_WIDTH-1:0];
            // Outside -128..127 when the top two bits disagree
            if (d[CELL_WIDTH] != d[CELL_WIDTH-1]) begin
                e = 1'b1;
            end
        end
        return {e, r};
    endfunction

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic logic [VECTOR_WIDTH-1:0] random_vector();
        logic [VECTOR_WIDTH-1:0] v;
        for (int i = 0; i < VECTOR_WIDTH; i++) begin
            v[i] = lfsr_bit();
        end
        return v;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Error reporting and driving
    //////////////////////////////////////////////////////////////////////

    task automatic report_mismatch(input string name, input logic [VECTOR_WIDTH-1:0] expected,
                                   input logic [VECTOR_WIDTH-1:0] actual);
        $display("FAILED at %0t: %s expected %h, got %h", $time, name, expected, actual);
        $display("TEST FAILED");
        $fatal(1, "mismatch on %s", name);
    endtask

    task automatic abort_run(input string what);
        $display("ERROR at %0t: %s", $time, what);
        $display("TEST FAILED");
        $fatal(1, "run stopped");
    endtask

    // Offer one pair and wait for the loader to take it
    task automatic send_vector(input logic [VECTOR_WIDTH-1:0] a,
                               input logic [VECTOR_WIDTH-1:0] b,
                               input logic [VECTOR_WIDTH:0]   expected);
        @(negedge clk);
        in_valid = 1'b1;
        in_a     = a;
        in_b     = b;
        do begin
            @(posedge clk);
        end while (!in_ready);
        exp_q.push_back(expected);
    endtask

    task automatic end_input();
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic drain_outputs();
        while (exp_q.size() != 0) @(posedge clk);
        @(negedge clk);
    endtask

    // Output monitor, gap tracking and stall watch
    always @(posedge clk) begin
        if (rst) begin
            gap_cnt = 0;
        end else if (out_valid && out_ready) begin
            assert (exp_q.size() != 0) else abort_run("output arrived with nothing expected");
            head = exp_q.pop_front();
            assert (out_result == head[VECTOR_WIDTH-1:0])
            else report_mismatch("out_result", head[VECTOR_WIDTH-1:0], out_result);
            assert (out_error == head[VECTOR_WIDTH])
            else report_mismatch("out_error", VECTOR_WIDTH'(head[VECTOR_WIDTH]),
                                 VECTOR_WIDTH'(out_error));
            if (gap_check && gap_armed) begin
                assert (gap_cnt < 4) else abort_run("more than 4 cycles between outputs");
            end
            gap_armed    = gap_check;
            gap_cnt      = 0;
            outputs_seen = outputs_seen + 1;
        end else begin
            gap_cnt = gap_cnt + 1;
        end
        if (out_valid && !out_ready && !in_ready) begin
            saw_in_stall = 1'b1;
        end
    end

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > TIMEOUT_CYCLES) begin
            abort_run("timeout, the vectors did not complete in time");
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Directed tests
    //////////////////////////////////////////////////////////////////////

    // Cell 4 listed first, cell 0 last
    task automatic reference_vectors();
        send_vector({8'hCE, 8'h28, 8'h1E, 8'h14, 8'hF6},
                    {8'h08, 8'h02, 8'hFD, 8'h19, 8'h05},
                    {1'b0, 8'hC6, 8'h26, 8'h21, 8'hFB, 8'hF1});
        end_input();
        drain_outputs();
    endtask

    task automatic overflow_flag();
        // 127 - (-50) wraps to -79
        send_vector({8'hCE, 8'h1E, 8'h14, 8'h7F, 8'hF6},
                    {8'hD1, 8'hFD, 8'h04, 8'hCE, 8'h05},
                    {1'b1, 8'hFD, 8'h21, 8'h10, 8'hB1, 8'hF1});
        // Only cell 4 overflows and it sits in the partial tile
        send_vector({8'h9C, 8'h01, 8'h02, 8'h03, 8'h04},
                    {8'h64, 8'h01, 8'h01, 8'h01, 8'h01},
                    {1'b1, 8'h38, 8'h00, 8'h01, 8'h02, 8'h03});
        // Range edges 127 and -127 without overflow
        send_vector({8'h0A, 8'hF6, 8'h64, 8'h9C, 8'h00},
                    {8'h14, 8'h0A, 8'hE5, 8'h1B, 8'h00},
                    {1'b0, 8'hF6, 8'hEC, 8'h7F, 8'h81, 8'h00});
        end_input();
        drain_outputs();
    endtask

    task automatic streaming_run();
        logic [VECTOR_WIDTH-1:0] a;
        logic [VECTOR_WIDTH-1:0] b;
        int                      start;
        gap_check = 1'b1;
        gap_armed = 1'b0;
        start     = outputs_seen;
        for (int i = 0; i < STREAM_LEN; i++) begin
            a = random_vector();
            b = random_vector();
            send_vector(a, b, model_diff(a, b));
        end
        end_input();
        drain_outputs();
        gap_check = 1'b0;
        assert (outputs_seen - start == STREAM_LEN) else abort_run("streamed vectors went missing");
    endtask

    task automatic backpressure_run();
        int start;
        for (int i = 0; i < STREAM_LEN; i++) begin
            stress_a[i] = random_vector();
            stress_b[i] = random_vector();
        end
        saw_in_stall = 1'b0;
        sending_done = 1'b0;
        start        = outputs_seen;
        fork
            begin
                for (int i = 0; i < STREAM_LEN; i++) begin
                    send_vector(stress_a[i], stress_b[i], model_diff(stress_a[i], stress_b[i]));
                end
                end_input();
                sending_done = 1'b1;
            end
            begin
                // Random output stalls until everything is out
                while (!sending_done || exp_q.size() != 0) begin
                    @(negedge clk);
                    out_ready = lfsr_bit();
                end
            end
        join
        @(negedge clk);
        out_ready = 1'b1;
        assert (outputs_seen - start == STREAM_LEN) else abort_run("stalled vectors went missing");
        assert (saw_in_stall) else abort_run("in_ready never dropped during an output stall");
    endtask

    task automatic midstream_reset();
        logic [VECTOR_WIDTH-1:0] a;
        logic [VECTOR_WIDTH-1:0] b;
        for (int i = 0; i < 3; i++) begin
            a = random_vector();
            b = random_vector();
            // 127 - (-128) overflows in cell 0
            a[CELL_WIDTH-1:0] = 8'h7F;
            b[CELL_WIDTH-1:0] = 8'h80;
            send_vector(a, b, model_diff(a, b));
        end
        // Tile 0 of the second vector lands in the error accumulator
        repeat (2) @(posedge clk);
        // Vectors still in flight here
        @(negedge clk);
        rst      = 1'b1;
        in_valid = 1'b0;
        exp_q.delete();
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        assert (!out_valid) else abort_run("out_valid high after a mid-stream reset");
        assert (in_ready) else abort_run("in_ready low after a mid-stream reset");
        send_vector({8'h01, 8'h02, 8'h03, 8'h04, 8'h05},
                    {8'h05, 8'h04, 8'h03, 8'h02, 8'h01},
                    {1'b0, 8'hFC, 8'hFE, 8'h00, 8'h02, 8'h04});
        end_input();
        drain_outputs();
    endtask

    initial begin
        clk          = 1'b0;
        rst          = 1'b1;
        in_valid     = 1'b0;
        in_a         = '0;
        in_b         = '0;
        out_ready    = 1'b1;
        gap_check    = 1'b0;
        gap_armed    = 1'b0;
        saw_in_stall = 1'b0;
        sending_done = 1'b0;
        cycle_cnt    = 0;
        gap_cnt      = 0;
        outputs_seen = 0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        reference_vectors();
        overflow_flag();
        streaming_run();
        backpressure_run();
        midstream_reset();
        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb/vector_subtract_chk.sv
`timescale 1ns/10ps
`default_nettype none

module vector_subtract_chk
    import vecsub_pkg::*;
(
    input wire logic                      clk,
    input wire logic                      rst,
    input wire logic                      in_valid,
    input wire logic                      in_ready,
    input wire logic [VECTOR_WIDTH-1:0]   in_a,
    input wire logic [VECTOR_WIDTH-1:0]   in_b,
    input wire logic                      op_valid,
    input wire logic                      op_ready,
    input wire logic [VECTOR_WIDTH-1:0]   op_a,
    input wire logic [VECTOR_WIDTH-1:0]   op_b,
    input wire logic                      tile_valid,
    input wire logic                      tile_ready,
    input wire logic [TILE_IDX_WIDTH-1:0] tile_index,
    input wire logic [TILE_WIDTH-1:0]     tile_diff,
    input wire logic                      tile_ovf,
    input wire logic                      out_valid,
    input wire logic                      out_ready,
    input wire logic [VECTOR_WIDTH-1:0]   out_result,
    input wire logic                      out_error
);

    //////////////////////////////////////////////////////////////////////
    // Stalled handshakes keep valid and data
    //////////////////////////////////////////////////////////////////////

    assert property (@(posedge clk) disable iff (rst)
        in_valid && !in_ready |=> in_valid && $stable(in_a) && $stable(in_b))
    else $error("input pair changed while stalled");

    // Loader to subtractor
    assert property (@(posedge clk) disable iff (rst)
        op_valid && !op_ready |=> op_valid && $stable(op_a) && $stable(op_b))
    else $error("operand pair changed while stalled");

    // Subtractor to collector
    assert property (@(posedge clk) disable iff (rst)
        tile_valid && !tile_ready |=> tile_valid && $stable(tile_index) &&
                                      $stable(tile_diff) && $stable(tile_ovf))
    else $error("tile changed while stalled");

    assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_result) && $stable(out_error))
    else $error("result changed while stalled");

    // Reset clears the output
    assert property (@(posedge clk) rst |=> !out_valid)
    else $error("out_valid high in the cycle after reset");

endmodule

bind vector_subtract vector_subtract_chk vector_subtract_chk_i (.*);

`default_nettype wire

// File: src/vector_subtract.sv
`timescale 1ns/10ps
`default_nettype none

module vector_subtract
    import vecsub_pkg::*;
(
    input  wire logic                    clk,
    input  wire logic                    rst,

    // Operand pair in
    input  wire logic                    in_valid,
    input  wire logic [VECTOR_WIDTH-1:0] in_a,
    input  wire logic [VECTOR_WIDTH-1:0] in_b,
    output logic                         in_ready,

    // Difference vector out
    output logic                         out_valid,
    output logic [VECTOR_WIDTH-1:0]      out_result,
    output logic                         out_error,
    input  wire logic                    out_ready
);

    //////////////////////////////////////////////////////////////////////
    // Internal links
    //////////////////////////////////////////////////////////////////////

    // Loader to subtractor
    logic                      op_valid;
    logic [VECTOR_WIDTH-1:0]   op_a;
    logic [VECTOR_WIDTH-1:0]   op_b;
    logic                      op_ready;

    // Subtractor to collector
    logic                      tile_valid;
    logic [TILE_IDX_WIDTH-1:0] tile_index;
    logic [TILE_WIDTH-1:0]     tile_diff;
    logic                      tile_ovf;
    logic                      tile_ready;

    operand_loader operand_loader_i (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .in_a     (in_a),
        .in_b     (in_b),
        .in_ready (in_ready),
        .op_valid (op_valid),
        .op_a     (op_a),
        .op_b     (op_b),
        .op_ready (op_ready)
    );

    // Walks the vector TILING cells at a time
    tile_subtractor tile_subtractor_i (
        .clk        (clk),
        .rst        (rst),
        .op_valid   (op_valid),
        .op_a       (op_a),
        .op_b       (op_b),
        .op_ready   (op_ready),
        .tile_valid (tile_valid),
        .tile_index (tile_index),
        .tile_diff  (tile_diff),
        .tile_ovf   (tile_ovf),
        .tile_ready (tile_ready)
    );

    result_collector result_collector_i (
        .clk        (clk),
        .rst        (rst),
        .tile_valid (tile_valid),
        .tile_index (tile_index),
        .tile_diff  (tile_diff),
        .tile_ovf   (tile_ovf),
        .tile_ready (tile_ready),
        .out_valid  (out_valid),
        .out_result (out_result),
        .out_error  (out_error),
        .out_ready  (out_ready)
    );

endmodule

`default_nettype wire

// File: src/result_collector.sv
`timescale 1ns/10ps
`default_nettype none

module result_collector
    import vecsub_pkg::*;
(
    input  wire logic                      clk,
    input  wire logic                      rst,

    // Tile of differences from the subtractor
    input  wire logic                      tile_valid,
    input  wire logic [TILE_IDX_WIDTH-1:0] tile_index,
    input  wire logic [TILE_WIDTH-1:0]     tile_diff,
    input  wire logic                      tile_ovf,
    output logic                           tile_ready,

    // Result vector to outside
    output logic                           out_valid,
    output logic [VECTOR_WIDTH-1:0]        out_result,
    output logic                           out_error,
    input  wire logic                      out_ready
);

    // Assembly buffer and running error
    logic [VECTOR_WIDTH-1:0] asm_buf;
    logic [VECTOR_WIDTH-1:0] asm_next;
    logic                    err_acc;
    logic                    last_tile;
    logic                    tile_fire;

    assign last_tile = (tile_index == TILE_IDX_WIDTH'(TILE_COUNT - 1));

    // Only the last tile waits on output register space
    assign tile_ready = !last_tile || !out_valid || out_ready;
    assign tile_fire  = tile_valid && tile_ready;

    //////////////////////////////////////////////////////////////////////
    // Tile merge
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        asm_next = asm_buf;
        for (int l = 0; l < TILING; l++) begin
            // Unused lanes of a partial tile dropped
            if (int'(tile_index) * TILING + l < VECTOR_LEN) begin
                asm_next[(int'(tile_index) * TILING + l) * CELL_WIDTH +: CELL_WIDTH] =
                    tile_diff[l*CELL_WIDTH +: CELL_WIDTH];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (tile_fire) begin
            asm_buf <= asm_next;
        end
        // Result and flag load together on the last tile
        if (tile_fire && last_tile) begin
            out_result <= asm_next;
            out_error  <= err_acc | tile_ovf;
        end
    end

    // Output valid and error accumulator
    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
            err_acc   <= 1'b0;
        end else begin
            if (tile_fire && last_tile) begin
                out_valid <= 1'b1;
                err_acc   <= 1'b0;
            end else begin
                if (out_ready) begin
                    out_valid <= 1'b0;
                end
                if (tile_fire) begin
                    err_acc <= err_acc | tile_ovf;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: src/tile_subtractor.sv
`timescale 1ns/10ps
`default_nettype none

module tile_subtractor
    import vecsub_pkg::*;
(
    input  wire logic                      clk,
    input  wire logic                      rst,

    // Operand pair from the loader
    input  wire logic                      op_valid,
    input  wire logic [VECTOR_WIDTH-1:0]   op_a,
    input  wire logic [VECTOR_WIDTH-1:0]   op_b,
    output logic                           op_ready,

    // Tile of differences to the collector
    output logic                           tile_valid,
    output logic [TILE_IDX_WIDTH-1:0]      tile_index,
    output logic [TILE_WIDTH-1:0]          tile_diff,
    output logic                           tile_ovf,
    input  wire logic                      tile_ready
);

    sub_state_t                state;

    // Operand copies shifted down one tile per issue
    logic [VECTOR_WIDTH-1:0]   a_q;
    logic [VECTOR_WIDTH-1:0]   b_q;

    // Next tile to issue
    logic [TILE_IDX_WIDTH-1:0] tile_cnt;

    logic [TILE_WIDTH-1:0]     diff_c;
    logic                      ovf_c;
    logic                      op_fire;
    logic                      issue;
    logic                      last_issue;

    // Idle and the output slot free or emptying this cycle
    assign op_ready   = (state == SUB_IDLE) && (!tile_valid || tile_ready);
    assign op_fire    = op_valid && op_ready;
    assign issue      = (state == SUB_RUN) && (!tile_valid || tile_ready);
    assign last_issue = issue && (tile_cnt == TILE_IDX_WIDTH'(TILE_COUNT - 1));

    //////////////////////////////////////////////////////////////////////
    // Lane subtractors
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        logic [CELL_WIDTH-1:0] ca;
        logic [CELL_WIDTH-1:0] cb;
        logic [CELL_WIDTH-1:0] cd;

        diff_c = '0;
        ovf_c  = 1'b0;
        for (int l = 0; l < TILING; l++) begin
            ca = a_q[l*CELL_WIDTH +: CELL_WIDTH];
            cb = b_q[l*CELL_WIDTH +: CELL_WIDTH];
            // Wraps on overflow keeping the low 8 bits
            cd = ca - cb;
            diff_c[l*CELL_WIDTH +: CELL_WIDTH] = cd;
            // Signs differ and result sign flipped away from a
            if (int'(tile_cnt) * TILING + l < VECTOR_LEN) begin
                ovf_c = ovf_c | ((ca[CELL_WIDTH-1] != cb[CELL_WIDTH-1]) &&
                                 (cd[CELL_WIDTH-1] != ca[CELL_WIDTH-1]));
            end
        end
    end

    // FSM and tile handshake
    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= SUB_IDLE;
            tile_cnt   <= '0;
            tile_valid <= 1'b0;
        end else begin
            case (state)
                SUB_IDLE: begin
                    if (op_fire) begin
                        state    <= SUB_RUN;
                        tile_cnt <= '0;
                    end
                end
                SUB_RUN: begin
                    if (issue) begin
                        tile_cnt <= tile_cnt + 1'b1;
                    end
                    // Back to idle once the last tile is out
                    if (last_issue) begin
                        state <= SUB_IDLE;
                    end
                end
                default: state <= SUB_IDLE;
            endcase

            if (issue) begin
                tile_valid <= 1'b1;
            end else if (tile_ready) begin
                tile_valid <= 1'b0;
            end
        end
    end

    // Operand copies and tile payload
    always_ff @(posedge clk) begin
        if (op_fire) begin
            a_q <= op_a;
            b_q <= op_b;
        end else if (issue) begin
            a_q <= a_q >> TILE_WIDTH;
            b_q <= b_q >> TILE_WIDTH;
        end
        if (issue) begin
            tile_diff  <= diff_c;
            tile_ovf   <= ovf_c;
            tile_index <= tile_cnt;
        end
    end

endmodule

`default_nettype wire

// File: src/operand_loader.sv
`timescale 1ns/10ps
`default_nettype none

module operand_loader
    import vecsub_pkg::*;
(
    input  wire logic                    clk,
    input  wire logic                    rst,

    // Operand pair from outside
    input  wire logic                    in_valid,
    input  wire logic [VECTOR_WIDTH-1:0] in_a,
    input  wire logic [VECTOR_WIDTH-1:0] in_b,
    output logic                         in_ready,

    // Operand pair to the subtractor
    output logic                         op_valid,
    output logic [VECTOR_WIDTH-1:0]      op_a,
    output logic [VECTOR_WIDTH-1:0]      op_b,
    input  wire logic                    op_ready
);

    // Buffer holds a pair not yet taken
    logic full;
    logic in_fire;
    logic op_fire;

    // Room when empty or when the held pair leaves this cycle
    assign in_ready = !full || op_ready;
    assign in_fire  = in_valid && in_ready;
    assign op_fire  = full && op_ready;

    assign op_valid = full;

    //////////////////////////////////////////////////////////////////////
    // Full flag
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            full <= 1'b0;
        end else if (in_fire) begin
            // Load wins over free, so a pair can stream straight through
            full <= 1'b1;
        end else if (op_fire) begin
            full <= 1'b0;
        end
    end

    // Operand storage
    always_ff @(posedge clk) begin
        if (in_fire) begin
            op_a <= in_a;
            op_b <= in_b;
        end
    end

endmodule

`default_nettype wire

// File: src/vecsub_pkg.sv
`default_nettype none

package vecsub_pkg;

    //////////////////////////////////////////////////////////////////////
    // Vector geometry
    //////////////////////////////////////////////////////////////////////

    // Cells per vector
    localparam int VECTOR_LEN = 5;

    // Signed two's-complement cell width shared by operands and result
    localparam int CELL_WIDTH = 8;

    // Packed vector with cell i at bits i*CELL_WIDTH and up
    localparam int VECTOR_WIDTH = VECTOR_LEN * CELL_WIDTH;

    //////////////////////////////////////////////////////////////////////
    // Tiling of the datapath
    //////////////////////////////////////////////////////////////////////

    // Cell differences computed per clock
    localparam int TILING = 2;

    // Tiles per vector rounded up so the last one may be partial
    localparam int TILE_COUNT = (VECTOR_LEN + TILING - 1) / TILING;

    // One tile of differences
    localparam int TILE_WIDTH = TILING * CELL_WIDTH;

    // Tile index width of at least one bit
    localparam int TILE_IDX_WIDTH = (TILE_COUNT > 1) ? $clog2(TILE_COUNT) : 1;

    // Tile subtractor states
    typedef enum logic {
        SUB_IDLE = 1'b0,
        SUB_RUN  = 1'b1
    } sub_state_t;

endpackage

`default_nettype wire
